//--- include/csa_config.svh
`ifndef CSA_CONFIG_SVH
`define CSA_CONFIG_SVH

// ------------------------------------------------------------
// accelerator sizing

`define CSA_UNIT_NUM 4 // 2, 4 and 8 are all valid
`define CSA_IDX_BITS $clog2(`CSA_UNIT_NUM)

// ------------------------------------------------------------
// register bank

`define CSA_ADDR_BITS 5 // word address width of the bank
`define CSA_TIMES_DEFAULT 32'd8 // iteration count after reset or a zero write
`define CSA_UNMAPPED_TAG 16'hE000 // upper half of an unmapped read

`endif

//--- source/csa_pkg.sv
`default_nettype none
`include "csa_config.svh"

package csa_pkg;

	typedef struct packed {
		logic [7:0] b4;
		logic [7:0] b3;
		logic [7:0] b2;
		logic [7:0] b1;
		logic [7:0] b0; // byte 0 sits in the low bits of the word
	} csa_in_t;

	typedef struct packed {
		logic [15:0] min;
		logic [15:0] max;
		logic [15:0] sum; // sum in the low half word, as out_data0
	} csa_out_t;

	typedef struct packed {
		logic [31:0] times;
		logic [31:0] delay;
	} calc_cfg_t;

	typedef struct packed {
		logic                      cyc;
		logic                      stb;
		logic                      we;
		logic [3:0]                sel;
		logic [`CSA_ADDR_BITS-1:0] adr;
		logic [31:0]               dat;
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wb_rsp_t;

	typedef enum logic [`CSA_ADDR_BITS-1:0] {
		addr_busy       = 0,
		addr_out_room   = 1,
		addr_channel    = 2,
		addr_in_valid   = 3,
		addr_in_data0   = 4,
		addr_in_data1   = 5,
		addr_in_data2   = 6,
		addr_in_data3   = 7,
		addr_in_data4   = 8,
		addr_out_valid  = 9,
		addr_out_data0  = 10,
		addr_out_data1  = 11,
		addr_out_data2  = 12,
		addr_calc_times = 13,
		addr_calc_delay = 14
	} reg_addr_e;

	typedef enum logic [1:0] {wait_unit, wait_data, take} dispatch_state_e;

	typedef enum logic {wait_room, wait_result} collect_state_e;

	typedef enum logic [1:0] {idle, wait_in, wait_out} valid_state_e;

endpackage

`default_nettype wire

//--- source/csa_calc_unit.sv
`default_nettype none
`timescale 1ns/100ps

module csa_calc_unit import csa_pkg::*; (
	input  wire            axi_mm_clk,
	input  wire            rst_n,
	input  wire calc_cfg_t calc_cfg,
	input  wire            start,
	input  wire csa_in_t   in_word,
	input  wire            clear,
	output logic           busy,
	output logic           done,
	output csa_out_t       result
);

	localparam logic [31:0] MIN_TIMES = 32'd5; // the five folds must fit before done

	logic [32:0] limit;
	logic [32:0] cnt;
	logic        fold;
	csa_in_t     word_q;
	logic [15:0] sum_q;
	logic [7:0]  max_q;
	logic [7:0]  min_q;

	assign limit = {1'b0, (calc_cfg.times < MIN_TIMES) ? MIN_TIMES : calc_cfg.times}
		+ {1'b0, calc_cfg.delay};
	assign fold = busy && !done && (cnt <= 33'd5); // one byte per cycle right after start

	// ------------------------------------------------------------
	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			done <= 1'b0;
			cnt  <= '0;
		end else if (clear) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else if (start) begin
			busy <= 1'b1;
			cnt  <= 33'd1; // counts cycles since the start edge
		end else if (busy && !done) begin
			cnt <= cnt + 33'd1;
			if (cnt >= limit) begin
				done <= 1'b1; // held until the collector clears the unit
			end
		end
	end

	// ------------------------------------------------------------
	always_ff @(posedge axi_mm_clk) begin
		if (start) begin
			word_q <= in_word;
			sum_q  <= '0;
			max_q  <= '0;
			min_q  <= '1;
		end else if (fold) begin
			word_q <= csa_in_t'({8'd0, word_q[39:8]}); // next byte drops into b0
			sum_q  <= sum_q + {8'd0, word_q.b0};
			if (word_q.b0 > max_q) begin
				max_q <= word_q.b0;
			end
			if (word_q.b0 < min_q) begin
				min_q <= word_q.b0;
			end
		end
	end

	assign result.sum = sum_q;
	assign result.max = {8'd0, max_q};
	assign result.min = {8'd0, min_q};

endmodule

`default_nettype wire

//--- source/csa_dispatch.sv
`default_nettype none
`timescale 1ns/100ps
`include "csa_config.svh"

module csa_dispatch import csa_pkg::*; (
	input  wire                       axi_mm_clk,
	input  wire                       rst_n,
	input  wire                       in_ready,
	output logic                      in_ren,
	input  wire csa_in_t              in_rdata,
	input  wire [`CSA_UNIT_NUM-1:0]   unit_busy,
	output logic [`CSA_UNIT_NUM-1:0]  unit_start,
	output csa_in_t                   unit_in,
	output logic                      in_seen,
	output logic [`CSA_IDX_BITS-1:0]  in_seen_idx
);

	localparam int IDX_BITS = `CSA_IDX_BITS;
	localparam logic [IDX_BITS-1:0] LAST = IDX_BITS'(`CSA_UNIT_NUM - 1);

	dispatch_state_e     state;
	logic [IDX_BITS-1:0] idx;

	assign in_ren = (state == wait_data) && in_ready; // one cycle, only while the port has data

	// ------------------------------------------------------------
	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			state      <= wait_unit;
			idx        <= '0;
			unit_start <= '0;
			in_seen    <= 1'b0;
		end else begin
			unit_start <= '0;
			in_seen    <= 1'b0;
			case (state)
				wait_unit: begin
					if (!unit_busy[idx]) begin
						state <= wait_data; // a stalled unit holds the whole rotation
					end
				end
				wait_data: begin
					if (in_ready) begin
						state <= take;
					end
				end
				take: begin
					unit_start[idx] <= 1'b1; // in_rdata is valid this cycle
					in_seen         <= 1'b1;
					idx             <= (idx == LAST) ? '0 : idx + 1'b1;
					state           <= wait_unit;
				end
				default: begin
					state <= wait_unit;
				end
			endcase
		end
	end

	// ------------------------------------------------------------
	always_ff @(posedge axi_mm_clk) begin
		if (state == take) begin
			unit_in     <= in_rdata;
			in_seen_idx <= idx;
		end
	end

endmodule

`default_nettype wire

//--- source/csa_collect.sv
`default_nettype none
`timescale 1ns/100ps
`include "csa_config.svh"

module csa_collect import csa_pkg::*; (
	input  wire                                axi_mm_clk,
	input  wire                                rst_n,
	input  wire                                out_full,
	output logic                               out_wen,
	output csa_out_t                           out_wdata,
	input  wire [`CSA_UNIT_NUM-1:0]            unit_done,
	input  wire csa_out_t [`CSA_UNIT_NUM-1:0]  unit_out,
	output logic [`CSA_UNIT_NUM-1:0]           unit_clear,
	output logic                               out_seen,
	output logic [`CSA_IDX_BITS-1:0]           out_seen_idx
);

	localparam int IDX_BITS = `CSA_IDX_BITS;
	localparam logic [IDX_BITS-1:0] LAST = IDX_BITS'(`CSA_UNIT_NUM - 1);

	collect_state_e      state;
	logic [IDX_BITS-1:0] idx;
	logic                pick;

	assign pick = (state == wait_result) && unit_done[idx]; // same rotation as the dispatcher

	// ------------------------------------------------------------
	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			state      <= wait_room;
			idx        <= '0;
			out_wen    <= 1'b0;
			unit_clear <= '0;
			out_seen   <= 1'b0;
		end else begin
			out_wen    <= 1'b0;
			unit_clear <= '0;
			out_seen   <= 1'b0;
			case (state)
				wait_room: begin
					if (!out_full) begin
						state <= wait_result;
					end
				end
				default: begin
					if (pick) begin
						out_wen         <= 1'b1;
						unit_clear[idx] <= 1'b1; // frees the unit for the next word
						out_seen        <= 1'b1;
						idx             <= (idx == LAST) ? '0 : idx + 1'b1;
						state           <= wait_room;
					end
				end
			endcase
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (pick) begin
			out_wdata    <= unit_out[idx];
			out_seen_idx <= idx;
		end
	end

endmodule

`default_nettype wire

//--- source/csa_regs.sv
`default_nettype none
`timescale 1ns/100ps
`include "csa_config.svh"

module csa_regs import csa_pkg::*; (
	input  wire                      axi_mm_clk,
	input  wire                      rst_n,
	input  wire wb_req_t             wb_req,
	output wb_rsp_t                  wb_rsp,
	input  wire                      in_ready,
	input  wire                      out_full,
	output calc_cfg_t                calc_cfg,
	input  wire                      in_seen,
	input  wire [`CSA_IDX_BITS-1:0]  in_seen_idx,
	input  wire csa_in_t             in_word,
	input  wire                      out_seen,
	input  wire [`CSA_IDX_BITS-1:0]  out_seen_idx,
	input  wire csa_out_t            out_word
);

	logic                     ack_q;
	logic [31:0]              rdat_q;
	logic                     req;
	logic                     wr;
	reg_addr_e                addr;
	logic                     chan_wr;
	logic [31:0]              times_wr;
	logic [`CSA_IDX_BITS-1:0] channel;
	logic                     in_hit;
	logic                     out_hit;
	logic                     in_valid;
	logic                     out_valid;
	valid_state_e             vstate;
	csa_in_t                  in_snap;
	csa_out_t                 out_snap;

	function automatic logic [31:0] merge_bytes(input logic [31:0] cur,
		input logic [31:0] wdat, input logic [3:0] sel);
		logic [31:0] res;
		res = cur;
		for (int i = 0; i < 4; i++) begin
			if (sel[i]) begin
				res[i*8 +: 8] = wdat[i*8 +: 8];
			end
		end
		return res;
	endfunction

	assign req      = wb_req.cyc && wb_req.stb && !ack_q; // ack low again after one cycle
	assign wr       = req && wb_req.we;
	assign addr     = reg_addr_e'(wb_req.adr);
	assign chan_wr  = wr && (addr == addr_channel) && (wb_req.dat < `CSA_UNIT_NUM);
	assign times_wr = merge_bytes(calc_cfg.times, wb_req.dat, wb_req.sel);
	assign in_hit   = in_seen && (in_seen_idx == channel);
	assign out_hit  = out_seen && (out_seen_idx == channel);

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = rdat_q;

	// ------------------------------------------------------------
	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			ack_q          <= 1'b0;
			channel        <= '0;
			calc_cfg.times <= `CSA_TIMES_DEFAULT;
			calc_cfg.delay <= '0;
		end else begin
			ack_q <= req;
			if (chan_wr) begin
				channel <= wb_req.dat[`CSA_IDX_BITS-1:0];
			end
			if (wr && (addr == addr_calc_times)) begin
				calc_cfg.times <= (times_wr == '0) ? `CSA_TIMES_DEFAULT : times_wr;
			end
			if (wr && (addr == addr_calc_delay)) begin
				calc_cfg.delay <= merge_bytes(calc_cfg.delay, wb_req.dat, wb_req.sel);
			end
		end
	end

	// ------------------------------------------------------------
	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			vstate    <= idle;
			in_valid  <= 1'b0;
			out_valid <= 1'b0;
		end else if (chan_wr) begin
			vstate    <= wait_in; // a new channel invalidates both snapshots
			in_valid  <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			case (vstate)
				wait_in: begin
					if (in_hit) begin
						in_valid <= 1'b1;
						vstate   <= wait_out;
					end
				end
				wait_out: begin
					if (out_hit) begin
						out_valid <= 1'b1;
						vstate    <= idle;
					end
				end
				default: begin
					vstate <= idle;
				end
			endcase
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (in_hit) begin
			in_snap <= in_word;
		end
		if (out_hit) begin
			out_snap <= out_word;
		end
	end

	// ------------------------------------------------------------
	always_ff @(posedge axi_mm_clk) begin
		if (req) begin
			case (addr)
				addr_busy:       rdat_q <= {31'd0, in_ready};
				addr_out_room:   rdat_q <= {31'd0, !out_full};
				addr_channel:    rdat_q <= 32'(channel);
				addr_in_valid:   rdat_q <= {31'd0, in_valid};
				addr_in_data0:   rdat_q <= {24'd0, in_snap.b0};
				addr_in_data1:   rdat_q <= {24'd0, in_snap.b1};
				addr_in_data2:   rdat_q <= {24'd0, in_snap.b2};
				addr_in_data3:   rdat_q <= {24'd0, in_snap.b3};
				addr_in_data4:   rdat_q <= {24'd0, in_snap.b4};
				addr_out_valid:  rdat_q <= {31'd0, out_valid};
				addr_out_data0:  rdat_q <= {16'd0, out_snap.sum};
				addr_out_data1:  rdat_q <= {16'd0, out_snap.max};
				addr_out_data2:  rdat_q <= {16'd0, out_snap.min};
				addr_calc_times: rdat_q <= calc_cfg.times;
				addr_calc_delay: rdat_q <= calc_cfg.delay;
				default: begin
					rdat_q <= {`CSA_UNMAPPED_TAG, {(16 - `CSA_ADDR_BITS){1'b0}}, wb_req.adr};
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/csa_top.sv
`default_nettype none
`timescale 1ns/100ps
`include "csa_config.svh"

module csa_top import csa_pkg::*; (
	input  wire            axi_mm_clk,
	input  wire            rst_n,
	input  wire wb_req_t   wb_req,
	output wire wb_rsp_t   wb_rsp,
	input  wire            in_ready,
	output wire            in_ren,
	input  wire csa_in_t   in_rdata,
	input  wire            out_full,
	output wire            out_wen,
	output wire csa_out_t  out_wdata
);

	wire calc_cfg_t                        calc_cfg;
	wire [`CSA_UNIT_NUM-1:0]               unit_start;
	wire csa_in_t                          unit_in;
	wire [`CSA_UNIT_NUM-1:0]               unit_busy;
	wire [`CSA_UNIT_NUM-1:0]               unit_done;
	wire csa_out_t [`CSA_UNIT_NUM-1:0]     unit_out;
	wire [`CSA_UNIT_NUM-1:0]               unit_clear;
	wire                                   in_seen;
	wire [`CSA_IDX_BITS-1:0]               in_seen_idx;
	wire                                   out_seen;
	wire [`CSA_IDX_BITS-1:0]               out_seen_idx;

	csa_regs csa_regs_i (
		.axi_mm_clk   (axi_mm_clk),
		.rst_n        (rst_n),
		.wb_req       (wb_req),
		.wb_rsp       (wb_rsp),
		.in_ready     (in_ready),
		.out_full     (out_full),
		.calc_cfg     (calc_cfg),
		.in_seen      (in_seen),
		.in_seen_idx  (in_seen_idx),
		.in_word      (unit_in), // the word handed to the unit this cycle
		.out_seen     (out_seen),
		.out_seen_idx (out_seen_idx),
		.out_word     (out_wdata)
	);

	csa_dispatch csa_dispatch_i (
		.axi_mm_clk  (axi_mm_clk),
		.rst_n       (rst_n),
		.in_ready    (in_ready),
		.in_ren      (in_ren),
		.in_rdata    (in_rdata),
		.unit_busy   (unit_busy),
		.unit_start  (unit_start),
		.unit_in     (unit_in),
		.in_seen     (in_seen),
		.in_seen_idx (in_seen_idx)
	);

	csa_collect csa_collect_i (
		.axi_mm_clk   (axi_mm_clk),
		.rst_n        (rst_n),
		.out_full     (out_full),
		.out_wen      (out_wen),
		.out_wdata    (out_wdata),
		.unit_done    (unit_done),
		.unit_out     (unit_out),
		.unit_clear   (unit_clear),
		.out_seen     (out_seen),
		.out_seen_idx (out_seen_idx)
	);

	// ------------------------------------------------------------
	for (genvar i = 0; i < `CSA_UNIT_NUM; i++) begin : g_unit
		csa_calc_unit csa_calc_unit_i (
			.axi_mm_clk (axi_mm_clk),
			.rst_n      (rst_n),
			.calc_cfg   (calc_cfg),
			.start      (unit_start[i]),
			.in_word    (unit_in),
			.clear      (unit_clear[i]),
			.busy       (unit_busy[i]),
			.done       (unit_done[i]),
			.result     (unit_out[i])
		);
	end

endmodule

`default_nettype wire

//--- tb/csa_tb_tasks.svh
`ifndef CSA_TB_TASKS_SVH
`define CSA_TB_TASKS_SVH

// ------------------------------------------------------------
// bookkeeping and reference model

function automatic int error_total();
	return errors + src_errors;
endfunction

task automatic begin_test(input string name);
	test_name = name;
	test_start_errors = error_total();
endtask

task automatic end_test();
	int n;
	n = error_total() - test_start_errors;
	tests_run++;
	if (n == 0) begin
		$display("%s: ok", test_name);
	end else begin
		tests_failed++;
		$display("%s: %0d errors", test_name, n);
	end
endtask

task automatic report_mismatch(input string what, input logic [31:0] exp,
	input logic [31:0] act);
	errors++;
	$display("mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
endtask

function automatic logic [7:0] lcg_byte();
	seed = seed * 32'd1103515245 + 32'd12345;
	return seed[23:16]; // low bits of an LCG cycle too quickly
endfunction

function automatic csa_out_t ref_calc(input csa_in_t w);
	csa_out_t   r;
	logic [7:0] b;
	r.sum = 16'd0;
	r.max = {8'd0, w.b0};
	r.min = {8'd0, w.b0};
	for (int k = 0; k < 5; k++) begin
		b = w[k*8 +: 8];
		r.sum = r.sum + {8'd0, b};
		if ({8'd0, b} > r.max) begin
			r.max = {8'd0, b};
		end
		if ({8'd0, b} < r.min) begin
			r.min = {8'd0, b};
		end
	end
	return r;
endfunction

// ------------------------------------------------------------
// Wishbone and stream helpers

task automatic wb_access(input logic we, input logic [`CSA_ADDR_BITS-1:0] adr,
	input logic [31:0] wdat, input logic [3:0] sel, output logic [31:0] rdat);
	int guard;
	@(negedge axi_mm_clk);
	wb_req.cyc = 1'b1;
	wb_req.stb = 1'b1;
	wb_req.we = we;
	wb_req.sel = sel;
	wb_req.adr = adr;
	wb_req.dat = wdat;
	@(negedge axi_mm_clk);
	guard = 1;
	while (!wb_rsp.ack && guard < 8) begin
		@(negedge axi_mm_clk);
		guard++;
	end
	if (!wb_rsp.ack) begin
		errors++;
		$display("%s: no Wishbone ack within 8 cycles at address %0d", test_name, adr);
	end
	rdat = wb_rsp.dat;
	wb_req = '0;
endtask

task automatic write_reg(input logic [`CSA_ADDR_BITS-1:0] adr, input logic [31:0] wdat,
	input logic [3:0] sel);
	logic [31:0] unused;
	wb_access(1'b1, adr, wdat, sel, unused);
endtask

task automatic check_reg(input string what, input logic [`CSA_ADDR_BITS-1:0] adr,
	input logic [31:0] exp);
	logic [31:0] rdat;
	wb_access(1'b0, adr, 32'd0, 4'h0, rdat);
	if (rdat !== exp) begin
		report_mismatch(what, exp, rdat);
	end
endtask

task automatic push_words(input int n);
	csa_in_t w;
	for (int i = 0; i < n; i++) begin
		for (int k = 0; k < 5; k++) begin
			w[k*8 +: 8] = lcg_byte();
		end
		sent_q.push_back(w);
	end
endtask

task automatic await_results(input int target);
	int guard;
	int limit;
	guard = 0;
	limit = (target - got_q.size() + UNITS) * CYC_PER_WORD;
	while (got_q.size() < target && guard < limit) begin
		@(negedge axi_mm_clk);
		guard++;
	end
	if (got_q.size() < target) begin
		errors++;
		$display("%s: only %0d of %0d results arrived before the timeout", test_name,
			got_q.size(), target);
	end
endtask

// results must come back in arrival order
task automatic compare_results();
	csa_out_t r;
	csa_out_t g;
	if (got_q.size() > sent_q.size()) begin
		errors++;
		$display("%s: %0d results for %0d words", test_name, got_q.size(), sent_q.size());
	end
	while (checked < got_q.size() && checked < sent_q.size()) begin
		r = ref_calc(sent_q[checked]);
		g = got_q[checked];
		if (g.sum !== r.sum) begin
			report_mismatch($sformatf("sum of word %0d", checked), {16'd0, r.sum}, {16'd0, g.sum});
		end
		if (g.max !== r.max) begin
			report_mismatch($sformatf("max of word %0d", checked), {16'd0, r.max}, {16'd0, g.max});
		end
		if (g.min !== r.min) begin
			report_mismatch($sformatf("min of word %0d", checked), {16'd0, r.min}, {16'd0, g.min});
		end
		checked++;
	end
endtask

// sink flagged full, then words are queued until the dispatcher stops reading
task automatic stall_stream(input int n, output int held);
	int got_before;
	int pops_before;
	int last;
	int still;
	int guard;
	@(negedge axi_mm_clk);
	out_full = 1'b1;
	got_before = got_q.size();
	pops_before = pop_count;
	push_words(n);
	last = pop_count;
	still = 0;
	guard = 0;
	while (still < QUIET_CYCLES && guard < (n + UNITS) * CYC_PER_WORD + QUIET_CYCLES) begin
		@(negedge axi_mm_clk);
		guard++;
		if (pop_count == last) begin
			still++;
		end else begin
			last = pop_count;
			still = 0;
		end
	end
	if (still < QUIET_CYCLES) begin
		errors++;
		$display("%s: the dispatcher kept reading while the sink was full", test_name);
	end
	held = got_q.size() - got_before; // a write whose room was seen before the flag rose
	if (held > 1) begin
		errors++;
		$display("%s: %0d writes while the sink was full", test_name, held);
	end
	if (pop_count - pops_before != UNITS + held) begin
		report_mismatch("words read while stalled", UNITS + held, pop_count - pops_before);
	end
endtask

// ------------------------------------------------------------
// directed tests

task automatic reset_and_map();
	begin_test("reset_and_map");
	check_reg("calc_times", addr_calc_times, `CSA_TIMES_DEFAULT);
	check_reg("calc_delay", addr_calc_delay, 32'd0);
	check_reg("channel", addr_channel, 32'd0);
	check_reg("in_valid", addr_in_valid, 32'd0);
	check_reg("out_valid", addr_out_valid, 32'd0);
	check_reg("unmapped 15", `CSA_ADDR_BITS'(15), {`CSA_UNMAPPED_TAG, 16'd15});
	check_reg("unmapped top", '1, {`CSA_UNMAPPED_TAG, 16'((1 << `CSA_ADDR_BITS) - 1)});
	end_test();
endtask

task automatic register_rules();
	begin_test("register_rules");
	write_reg(addr_channel, 32'd1, 4'hF);
	write_reg(addr_channel, 32'(UNITS), 4'hF);
	check_reg("channel after out of range write", addr_channel, 32'd1);
	write_reg(addr_calc_times, 32'd20, 4'hF);
	check_reg("calc_times", addr_calc_times, 32'd20);
	write_reg(addr_calc_times, 32'd0, 4'hF);
	check_reg("calc_times after zero write", addr_calc_times, `CSA_TIMES_DEFAULT);
	write_reg(addr_calc_delay, 32'd5, 4'hF);
	check_reg("calc_delay", addr_calc_delay, 32'd5);
	write_reg(addr_calc_delay, 32'hAAAA_AA07, 4'b0001); // only byte lane 0 lands
	check_reg("calc_delay byte lane", addr_calc_delay, 32'd7);
	write_reg(addr_calc_delay, 32'(STREAM_DELAY), 4'hF);
	write_reg(addr_channel, 32'd0, 4'hF);
	end_test();
endtask

task automatic stream_results();
	begin_test("stream_results");
	push_words(12);
	await_results(sent_q.size());
	compare_results();
	end_test();
endtask

task automatic back_pressure();
	int held;
	begin_test("back_pressure");
	stall_stream(2 * UNITS, held);
	@(negedge axi_mm_clk);
	out_full = 1'b0;
	await_results(sent_q.size());
	compare_results();
	end_test();
endtask

task automatic snapshot_valid();
	csa_in_t     w;
	csa_out_t    r;
	int          first;
	int          last;
	logic [15:0] fields [3];
	begin_test("snapshot_valid");
	write_reg(addr_channel, 32'(SNAP_CHAN), 4'hF);
	check_reg("in_valid after select", addr_in_valid, 32'd0);
	first = sent_q.size();
	push_words(8);
	await_results(sent_q.size());
	compare_results();
	last = first;
	for (int i = first; i < sent_q.size(); i++) begin
		if (i % UNITS == SNAP_CHAN) begin
			last = i; // word i went to unit i mod UNITS
		end
	end
	w = sent_q[last];
	r = ref_calc(w);
	fields = '{r.sum, r.max, r.min};
	check_reg("in_valid", addr_in_valid, 32'd1);
	check_reg("out_valid", addr_out_valid, 32'd1);
	for (int k = 0; k < 5; k++) begin
		check_reg($sformatf("in_data%0d", k), `CSA_ADDR_BITS'(addr_in_data0 + k),
			{24'd0, w[k*8 +: 8]});
	end
	for (int k = 0; k < 3; k++) begin
		check_reg($sformatf("out_data%0d", k), `CSA_ADDR_BITS'(addr_out_data0 + k),
			{16'd0, fields[k]});
	end
	end_test();
endtask

task automatic status_bits();
	int held;
	begin_test("status_bits");
	check_reg("busy with source empty", addr_busy, 32'd0);
	check_reg("out_room with sink open", addr_out_room, 32'd1);
	stall_stream(UNITS + 2, held);
	check_reg("busy with words waiting", addr_busy, 32'd1);
	check_reg("out_room with sink full", addr_out_room, 32'd0);
	src_on = 1'b0;
	check_reg("busy with source held", addr_busy, 32'd0);
	@(negedge axi_mm_clk);
	out_full = 1'b0;
	check_reg("out_room after release", addr_out_room, 32'd1);
	src_on = 1'b1;
	await_results(sent_q.size());
	compare_results();
	end_test();
endtask

`endif

//--- tb/tb_csa_top.sv
`default_nettype none
`timescale 1ns/100ps
`include "csa_config.svh"

module tb_csa_top import csa_pkg::*; ();

	localparam int UNITS = `CSA_UNIT_NUM;
	localparam int STREAM_DELAY = 0; // calc_delay while words stream
	localparam int CYC_PER_WORD = `CSA_TIMES_DEFAULT + STREAM_DELAY + 10;
	localparam int QUIET_CYCLES = 2 * CYC_PER_WORD;
	localparam int SNAP_CHAN = (UNITS > 2) ? 2 : 1;
	localparam int TOTAL_WORDS = 12 + 2 * UNITS + 8 + UNITS + 2;
	localparam int BUS_OPS = 64;
	localparam int WATCHDOG_CYCLES = 3 * (TOTAL_WORDS * CYC_PER_WORD + BUS_OPS * 4) + 100;

	logic        axi_mm_clk;
	logic        rst_n;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	logic        in_ready = 1'b0;
	logic        in_ren;
	csa_in_t     in_rdata = '0;
	logic        out_full;
	logic        out_wen;
	csa_out_t    out_wdata;

	csa_in_t     sent_q[$]; // every word in the order it was queued
	csa_out_t    got_q[$]; // every word the sink received
	logic        src_on;
	logic        ren_q = 1'b0;
	int          pop_count = 0;
	int          src_errors = 0;
	int          checked;
	int unsigned seed;
	string       test_name;
	int          errors;
	int          test_start_errors;
	int          tests_run;
	int          tests_failed;

	csa_top csa_top_i (
		.axi_mm_clk (axi_mm_clk),
		.rst_n      (rst_n),
		.wb_req     (wb_req),
		.wb_rsp     (wb_rsp),
		.in_ready   (in_ready),
		.in_ren     (in_ren),
		.in_rdata   (in_rdata),
		.out_full   (out_full),
		.out_wen    (out_wen),
		.out_wdata  (out_wdata)
	);

	`include "csa_tb_tasks.svh"

	initial begin
		axi_mm_clk = 1'b0;
		forever #50 axi_mm_clk = ~axi_mm_clk;
	end

	// ------------------------------------------------------------
	// FIFO models

	always @(posedge axi_mm_clk) begin
		ren_q <= in_ren; // the word follows in the cycle after the ren pulse
	end

	always @(negedge axi_mm_clk) begin
		if (ren_q) begin
			if (pop_count >= sent_q.size()) begin
				src_errors++;
				$display("in_ren pulsed while the source FIFO was empty");
			end else begin
				in_rdata = sent_q[pop_count];
				pop_count++;
			end
		end
		in_ready = src_on && (pop_count < sent_q.size());
	end

	always @(negedge axi_mm_clk) begin
		if (out_wen) begin
			got_q.push_back(out_wdata);
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge axi_mm_clk);
		$display("watchdog expired after %0d cycles, the run hung", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	// ------------------------------------------------------------
	initial begin
		seed = 59;
		errors = 0;
		checked = 0;
		tests_run = 0;
		tests_failed = 0;
		rst_n = 1'b0;
		wb_req = '0;
		out_full = 1'b0;
		src_on = 1'b1;
		repeat (8) @(negedge axi_mm_clk);
		rst_n = 1'b1;
		reset_and_map();
		register_rules();
		stream_results();
		back_pressure();
		snapshot_valid();
		status_bits();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
			error_total());
		if (error_total() == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
+incdir+tb
source/csa_pkg.sv
source/csa_calc_unit.sv
source/csa_dispatch.sv
source/csa_collect.sv
source/csa_regs.sv
source/csa_top.sv
tb/tb_csa_top.sv

//--- Makefile
TOP = tb_csa_top

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and look for the pass line"
	@echo "  clean  remove the Verilator build folder"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/100ps --top-module $(TOP) \
		-Mdir obj_dir -f files.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir
